/* flist.f */
common/dcache_pkg.sv
common/fill_if.sv
dcache/cache_way.sv
dcache/lru_stack.sv
dcache/dcache_array.sv
hw/credit_counter.sv
hw/miss_fsm.sv
hw/dcache_top.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator and run; success only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module dcache_tb -o dcache_sim \
  && ./obj_dir/dcache_sim | tee /dev/stderr | grep -qx "Test passed" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation failed or did not build"; exit 1; }

/* sim/dcache_tb.sv */
// memory model answers in request order after 1..6 cycles, 8 more in slow rows; 100-cycle timeout
`timescale 1ns/1ns

module dcache_tb
  import dcache_pkg::*;
();

  localparam logic [63:0] data_key     = 64'h5a5a_c3c3_0f0f_9696;
  localparam int          busy_timeout = 100;

  typedef struct {
    string       name;
    bit          write;
    bit          slow;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [63:0] wdata;
    bit          h1;
    bit          h2;
    logic [63:0] d1;
    logic [63:0] d2;
  } row_t;

  logic        clock;
  logic        reset;
  logic        rd_valid;
  logic [31:0] rd1_addr;
  logic [31:0] rd2_addr;
  logic        wr_en;
  logic [31:0] wr_addr;
  logic [63:0] wr_data;
  logic        rd1_hit;
  logic [63:0] rd1_data;
  logic        rd2_hit;
  logic [63:0] rd2_data;
  logic        busy;
  logic        mem_req_valid;
  logic [31:0] mem_req_addr;
  logic        mem_resp_valid;
  logic [63:0] mem_resp_data;
  logic        mem_credit;

  row_t        rows[$];
  // memory model queue, oldest request first
  logic [31:0] req_addr_q[$];
  int          req_due_q[$];
  int          req_total = 0;
  int          cycle     = 0;
  int          mem_delay;
  int          seed;
  bit          slow_mode = 1'b0;
  bit          timed_out = 1'b0;
  int          errors    = 0;
  int          tests_ok  = 0;
  int          tests_bad = 0;

  dcache_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] word_addr(input int tag, input int set, input int off);
    return {tag[22:0], set[3:0], off[1:0], 3'b000};
  endfunction

  // memory contents: word address xor a fixed key
  function automatic logic [63:0] mem_word(input logic [31:0] a);
    return {32'h0, a[31:3], 3'b000} ^ data_key;
  endfunction

  // five tags sharing set 9
  function automatic logic [31:0] lru_addr(input int k);
    return word_addr(32'h100 + k, 9, 0);
  endfunction

  // answers go out 1 ns after the edge, credit rides along
  always @(posedge clock) begin
    cycle = cycle + 1;
    #1;
    mem_resp_valid = 1'b0;
    mem_credit     = 1'b0;
    if (req_addr_q.size() > 0 && cycle >= req_due_q[0]) begin
      mem_resp_valid = 1'b1;
      mem_credit     = 1'b1;
      mem_resp_data  = mem_word(req_addr_q.pop_front());
      req_due_q.delete(0);
    end
  end

  // requests sampled mid-cycle, issued on the next edge
  always @(negedge clock) begin
    if (!reset && mem_req_valid) begin
      mem_delay = 1 + int'({$random(seed)} % 32'd6);
      if (slow_mode) begin
        mem_delay = mem_delay + 8;
      end
      req_addr_q.push_back(mem_req_addr);
      req_due_q.push_back(cycle + mem_delay);
      req_total = req_total + 1;
      if (req_addr_q.size() > mem_credits) begin
        $display("FAILED at %0t: %0d requests outstanding", $time, req_addr_q.size());
        errors = errors + 1;
      end
    end
  end

  task automatic add_row(input string name, input bit write, input bit slow,
                         input logic [31:0] a1, input logic [31:0] a2,
                         input logic [63:0] wdata, input bit h1, input bit h2,
                         input logic [63:0] d1, input logic [63:0] d2);
    row_t r;
    r = '{name, write, slow, a1, a2, wdata, h1, h2, d1, d2};
    rows.push_back(r);
  endtask

  // read row, data expected from memory
  task automatic add_read(input string name, input bit slow, input logic [31:0] a1,
                          input logic [31:0] a2, input bit h1, input bit h2);
    add_row(name, 1'b0, slow, a1, a2, 64'h0, h1, h2, mem_word(a1), mem_word(a2));
  endtask

  task automatic add_one(input string name, input logic [31:0] a, input bit h);
    add_read(name, 1'b0, a, a, h, h);
  endtask

  task automatic build_table();
    logic [31:0] wa;
    logic [63:0] wd;
    wa = word_addr(32'h020, 2, 1);
    wd = 64'hdead_beef_0123_4567;
    add_one("cold read misses", word_addr(32'h010, 1, 0), 1'b0);
    add_one("filled word hits", word_addr(32'h010, 1, 0), 1'b1);
    add_row("host write", 1'b1, 1'b0, wa, wa, wd, 1'b0, 1'b0, 64'h0, 64'h0);
    add_row("written word hits", 1'b0, 1'b0, wa, wa, 64'h0, 1'b1, 1'b1, wd, wd);
    add_one("neighbour word misses", word_addr(32'h020, 2, 2), 1'b0);
    add_read("dual miss", 1'b0, word_addr(32'h030, 3, 0), word_addr(32'h031, 4, 1),
             1'b0, 1'b0);
    add_read("dual hit", 1'b0, word_addr(32'h030, 3, 0), word_addr(32'h031, 4, 1),
             1'b1, 1'b1);
    add_one("lru fill a", lru_addr(1), 1'b0);
    add_one("lru fill b", lru_addr(2), 1'b0);
    add_one("lru fill c", lru_addr(3), 1'b0);
    add_one("lru fill d", lru_addr(4), 1'b0);
    add_one("lru touch a", lru_addr(1), 1'b1);
    add_one("lru touch c", lru_addr(3), 1'b1);
    // b least recent now, e takes its way
    add_one("lru fill e", lru_addr(5), 1'b0);
    add_one("lru keeps a", lru_addr(1), 1'b1);
    add_one("lru keeps c", lru_addr(3), 1'b1);
    add_one("lru keeps e", lru_addr(5), 1'b1);
    add_one("lru keeps d", lru_addr(4), 1'b1);
    add_one("lru b evicted", lru_addr(2), 1'b0);
    // order was d e c a, so a goes next
    add_one("lru a evicted", lru_addr(1), 1'b0);
    add_read("slow dual miss", 1'b1, word_addr(32'h040, 6, 3), word_addr(32'h041, 7, 2),
             1'b0, 1'b0);
    add_read("slow same block", 1'b1, word_addr(32'h042, 6, 0), word_addr(32'h042, 6, 1),
             1'b0, 1'b0);
  endtask

  task automatic check_lookup(input bit h1, input bit h2, input logic [63:0] d1,
                              input logic [63:0] d2, input string what);
    if (rd1_hit !== h1 || rd2_hit !== h2) begin
      $display("FAILED at %0t: %s hits %b%b, expected %b%b", $time, what,
               rd1_hit, rd2_hit, h1, h2);
      errors = errors + 1;
    end
    if (h1 && rd1_data !== d1) begin
      $display("FAILED at %0t: %s rd1_data %h, expected %h", $time, what, rd1_data, d1);
      errors = errors + 1;
    end
    if (h2 && rd2_data !== d2) begin
      $display("FAILED at %0t: %s rd2_data %h, expected %h", $time, what, rd2_data, d2);
      errors = errors + 1;
    end
  endtask

  // polls busy once per cycle at a stable point
  task automatic wait_idle(output bit idle);
    int n;
    idle = 1'b0;
    n    = 0;
    while (!idle && n < busy_timeout) begin
      @(posedge clock);
      #3;
      idle = (busy === 1'b0);
      n    = n + 1;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   err_before;
    int   req_before;
    int   want_req;
    bit   idle;
    r          = rows[idx];
    err_before = errors;
    req_before = req_total;
    slow_mode  = r.slow;
    @(posedge clock);
    #1;
    if (r.write) begin
      wr_en   = 1'b1;
      wr_addr = r.a1;
      wr_data = r.wdata;
      @(posedge clock);
      #1;
      wr_en = 1'b0;
    end else begin
      rd_valid = 1'b1;
      rd1_addr = r.a1;
      rd2_addr = r.a2;
      #2;
      check_lookup(r.h1, r.h2, r.d1, r.d2, "lookup");
      if (!r.h1 || !r.h2) begin
        @(posedge clock);
        #3;
        if (busy !== 1'b1) begin
          $display("FAILED at %0t: busy low after a miss", $time);
          errors = errors + 1;
        end
        wait_idle(idle);
        if (!idle) begin
          $display("test %0d %s: busy stayed high for %0d cycles", idx, r.name, busy_timeout);
          errors    = errors + 1;
          timed_out = 1'b1;
        end else begin
          check_lookup(1'b1, 1'b1, r.d1, r.d2, "after fill");
        end
        // a duplicate word is fetched once
        want_req = int'(!r.h1) + int'(!r.h2)
                 - int'(!r.h1 && !r.h2 && r.a1[31:3] == r.a2[31:3]);
        if (req_total - req_before != want_req) begin
          $display("FAILED at %0t: %0d requests, expected %0d", $time,
                   req_total - req_before, want_req);
          errors = errors + 1;
        end
      end
      @(posedge clock);
      #1;
      rd_valid = 1'b0;
    end
    if (errors == err_before) begin
      $display("test %0d %s: ok", idx, r.name);
      tests_ok = tests_ok + 1;
    end else begin
      $display("test %0d %s: %0d errors", idx, r.name, errors - err_before);
      tests_bad = tests_bad + 1;
    end
  endtask

  initial begin
    seed           = 7049;
    reset          = 1'b1;
    rd_valid       = 1'b0;
    rd1_addr       = '0;
    rd2_addr       = '0;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_data        = '0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    mem_credit     = 1'b0;
    build_table();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    #2;
    if (busy !== 1'b0 || mem_req_valid !== 1'b0) begin
      $display("FAILED at %0t: busy or mem_req_valid high after reset", $time);
      errors = errors + 1;
    end
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      run_row(i);
    end
    $display("summary: %0d tests ok, %0d with errors, %0d check errors",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim/dcache_assertions.sv */
// port-level checks on dcache_top, bound to every instance of it
`timescale 1ns/1ns

module dcache_assertions
  import dcache_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic rd_valid,
  input logic rd1_hit,
  input logic rd2_hit,
  input logic busy,
  input logic mem_req_valid,
  input logic mem_resp_valid
);

  // requests issued minus responses seen
  logic [2:0] in_flight;

  always_ff @(posedge clock) begin
    if (reset) begin
      in_flight <= 3'd0;
    end else begin
      in_flight <= in_flight + 3'(mem_req_valid) - 3'(mem_resp_valid);
    end
  end

  // quiet once reset has been applied
  assert property (@(posedge clock) reset |=> !busy && !mem_req_valid)
    else $error("busy or mem_req_valid high after reset");

  // requests only from the miss engine
  assert property (@(posedge clock) disable iff (reset) mem_req_valid |-> busy)
    else $error("mem_req_valid while not busy");

  assert property (@(posedge clock) disable iff (reset) (rd1_hit || rd2_hit) |-> rd_valid)
    else $error("hit reported without rd_valid");

  assert property (@(posedge clock) disable iff (reset) in_flight <= 3'(mem_credits))
    else $error("more requests outstanding than credits");

endmodule

bind dcache_top dcache_assertions u_assertions (
  .clock          (clock),
  .reset          (reset),
  .rd_valid       (rd_valid),
  .rd1_hit        (rd1_hit),
  .rd2_hit        (rd2_hit),
  .busy           (busy),
  .mem_req_valid  (mem_req_valid),
  .mem_resp_valid (mem_resp_valid)
);

/* hw/dcache_top.sv */
// cache top; host must hold read addresses and not write while busy, responses always taken
`timescale 1ns/1ns

module dcache_top (
  input  logic        clock,
  input  logic        reset,
  // host
  input  logic        rd_valid,
  input  logic [31:0] rd1_addr,
  input  logic [31:0] rd2_addr,
  input  logic        wr_en,
  input  logic [31:0] wr_addr,
  input  logic [63:0] wr_data,
  output logic        rd1_hit,
  output logic [63:0] rd1_data,
  output logic        rd2_hit,
  output logic [63:0] rd2_data,
  output logic        busy,
  // memory
  output logic        mem_req_valid,
  output logic [31:0] mem_req_addr,
  input  logic        mem_resp_valid,
  input  logic [63:0] mem_resp_data,
  input  logic        mem_credit
);

  logic       have_credit;
  logic       issue;
  logic [1:0] outstanding;

  // miss engine fills
  fill_if u_fill ();
  // array write port
  fill_if u_array_wr ();

  // host owns the port only while idle
  assign u_array_wr.valid    = busy ? u_fill.valid : wr_en;
  assign u_array_wr.addr.raw = busy ? u_fill.addr.raw : wr_addr;
  assign u_array_wr.data     = busy ? u_fill.data : wr_data;

  dcache_array u_array (
    .clock    (clock),
    .reset    (reset),
    .rd_valid (rd_valid),
    .rd1_addr (rd1_addr),
    .rd2_addr (rd2_addr),
    .wr       (u_array_wr.sink),
    .rd1_hit  (rd1_hit),
    .rd2_hit  (rd2_hit),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data)
  );

  miss_fsm u_miss (
    .clock          (clock),
    .reset          (reset),
    .rd_valid       (rd_valid),
    .rd1_hit        (rd1_hit),
    .rd2_hit        (rd2_hit),
    .rd1_addr       (rd1_addr),
    .rd2_addr       (rd2_addr),
    .have_credit    (have_credit),
    .outstanding    (outstanding),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .fill           (u_fill.fill),
    .issue          (issue),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .busy           (busy)
  );

  credit_counter u_credit (
    .clock         (clock),
    .reset         (reset),
    .issue         (issue),
    .credit_return (mem_credit),
    .resp          (mem_resp_valid),
    .have_credit   (have_credit),
    .outstanding   (outstanding)
  );

endmodule

/* hw/miss_fsm.sv */
// miss engine; up to two missing words per lookup, memory must answer in request order
`timescale 1ns/1ns

module miss_fsm
  import dcache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         rd_valid,
  input  logic         rd1_hit,
  input  logic         rd2_hit,
  input  dcache_addr_u rd1_addr,
  input  dcache_addr_u rd2_addr,
  input  logic         have_credit,
  input  logic [1:0]   outstanding,
  input  logic         mem_resp_valid,
  input  logic [63:0]  mem_resp_data,
  fill_if.fill         fill,
  output logic         issue,
  output logic         mem_req_valid,
  output logic [31:0]  mem_req_addr,
  output logic         busy
);

  logic [1:0] state;
  logic [1:0] state_next;

  // two-entry order queue of word addresses
  dcache_addr_u pend [2];
  logic         pend_two;
  logic         issue_ptr;
  logic         resp_ptr;

  logic miss1;
  logic miss2;
  logic same_word;
  logic last_issue;

  assign miss1      = rd_valid && !rd1_hit;
  assign miss2      = rd_valid && !rd2_hit;
  // both ports on one 64-bit word
  assign same_word  = (rd1_addr.raw[31:3] == rd2_addr.raw[31:3]);
  assign last_issue = (issue_ptr == pend_two);

  // one request per cycle while a credit is held
  assign mem_req_valid = (state == st_request) && have_credit;
  assign issue         = mem_req_valid;
  assign mem_req_addr  = pend[issue_ptr].raw;
  assign busy          = (state != st_idle);

  // each response fills the oldest issued word
  assign fill.valid = mem_resp_valid;
  assign fill.addr  = pend[resp_ptr];
  assign fill.data  = mem_resp_data;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (miss1 || miss2) begin
          state_next = st_request;
        end
      end
      st_request: begin
        if (issue && last_issue) begin
          state_next = st_wait;
        end
      end
      st_wait: begin
        // all fills written, busy drops
        if (outstanding == 2'd0) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      issue_ptr <= 1'b0;
      resp_ptr  <= 1'b0;
    end else begin
      state <= state_next;
      if (state == st_idle) begin
        issue_ptr <= 1'b0;
        resp_ptr  <= 1'b0;
      end else begin
        if (issue) begin
          issue_ptr <= !issue_ptr;
        end
        if (mem_resp_valid) begin
          resp_ptr <= !resp_ptr;
        end
      end
    end
  end

  // capture on leaving idle; a duplicate rd2 word is dropped
  always_ff @(posedge clock) begin
    if ((state == st_idle) && (miss1 || miss2)) begin
      pend[0].raw <= {(miss1 ? rd1_addr.raw[31:3] : rd2_addr.raw[31:3]), 3'b000};
      pend[1].raw <= {rd2_addr.raw[31:3], 3'b000};
      pend_two    <= miss1 && miss2 && !same_word;
    end
  end

endmodule

/* hw/credit_counter.sv */
// credit and outstanding counters for the memory request channel; 2-bit, so mem_credits <= 3
`timescale 1ns/1ns

module credit_counter
  import dcache_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       issue,
  input  logic       credit_return,
  input  logic       resp,
  output logic       have_credit,
  output logic [1:0] outstanding
);

  // credits memory still grants
  logic [1:0] credits;

  assign have_credit = (credits != 2'd0);

  always_ff @(posedge clock) begin
    if (reset) begin
      credits     <= 2'(mem_credits);
      outstanding <= 2'd0;
    end else begin
      // issue and return in one cycle cancel
      credits     <= credits - 2'(issue) + 2'(credit_return);
      // requests sent but not yet answered
      outstanding <= outstanding + 2'(issue) - 2'(resp);
    end
  end

endmodule

/* dcache/dcache_array.sv */
// 4-way array with true LRU; hits reported only with rd_valid, one write or fill per cycle
`timescale 1ns/1ns

module dcache_array
  import dcache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         rd_valid,
  input  dcache_addr_u rd1_addr,
  input  dcache_addr_u rd2_addr,
  fill_if.sink         wr,
  output logic         rd1_hit,
  output logic         rd2_hit,
  output logic [63:0]  rd1_data,
  output logic [63:0]  rd2_data
);

  logic [num_way-1:0] rd1_match;
  logic [num_way-1:0] rd2_match;
  logic [num_way-1:0] wr_match;
  logic [num_way-1:0] wr_sel;
  logic [63:0]        rd1_word [num_way];
  logic [63:0]        rd2_word [num_way];

  way_t rd1_way;
  way_t rd2_way;
  way_t wr_hit_way;
  way_t wr_way;
  way_t lru_way;
  logic wr_replace;

  // lru update
  logic touch;
  set_t touch_set;
  way_t touch_way;

  // match vector to way number, lowest way wins
  function automatic way_t encode_way(input logic [num_way-1:0] match);
    way_t w;
    w = '0;
    for (int i = num_way - 1; i >= 0; i--) begin
      if (match[i]) begin
        w = way_t'(i);
      end
    end
    return w;
  endfunction

  for (genvar w = 0; w < num_way; w++) begin : g_way
    cache_way u_way (
      .clock      (clock),
      .reset      (reset),
      .rd1_set    (rd1_addr.f.set),
      .rd2_set    (rd2_addr.f.set),
      .rd1_off    (rd1_addr.f.off),
      .rd2_off    (rd2_addr.f.off),
      .rd1_tag    (rd1_addr.f.tag),
      .rd2_tag    (rd2_addr.f.tag),
      .wr         (wr),
      .wr_sel     (wr_sel[w]),
      .wr_replace (wr_replace),
      .rd1_match  (rd1_match[w]),
      .rd2_match  (rd2_match[w]),
      .wr_match   (wr_match[w]),
      .rd1_word   (rd1_word[w]),
      .rd2_word   (rd2_word[w])
    );
  end

  assign rd1_way    = encode_way(rd1_match);
  assign rd2_way    = encode_way(rd2_match);
  assign wr_hit_way = encode_way(wr_match);

  // hit flags and read words
  assign rd1_hit  = rd_valid && (|rd1_match);
  assign rd2_hit  = rd_valid && (|rd2_match);
  assign rd1_data = rd1_word[rd1_way];
  assign rd2_data = rd2_word[rd2_way];

  // owning way if any, else the set's victim with its line cleared
  assign wr_replace = !(|wr_match);
  assign wr_way     = wr_replace ? lru_way : wr_hit_way;
  assign wr_sel     = num_way'(1) << wr_way;

  // write beats rd1, rd1 beats rd2
  always_comb begin
    touch     = 1'b0;
    touch_set = wr.addr.f.set;
    touch_way = wr_way;
    if (wr.valid) begin
      touch = 1'b1;
    end else if (rd1_hit) begin
      touch     = 1'b1;
      touch_set = rd1_addr.f.set;
      touch_way = rd1_way;
    end else if (rd2_hit) begin
      touch     = 1'b1;
      touch_set = rd2_addr.f.set;
      touch_way = rd2_way;
    end
  end

  lru_stack u_lru (
    .clock     (clock),
    .reset     (reset),
    .touch     (touch),
    .touch_set (touch_set),
    .touch_way (touch_way),
    .query_set (wr.addr.f.set),
    .lru_way   (lru_way)
  );

endmodule

/* dcache/lru_stack.sv */
// true LRU for every set, one touch per cycle; way 0 is most recent after reset
`timescale 1ns/1ns

module lru_stack
  import dcache_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic touch,
  input  set_t touch_set,
  input  way_t touch_way,
  input  set_t query_set,
  output way_t lru_way
);

  // entry 0 most recent, last entry is the victim
  way_t stack [num_set][num_way];

  // slot of the touched way in its set
  way_t touch_pos;

  always_comb begin
    touch_pos = way_t'(num_way - 1);
    for (int i = 0; i < num_way; i++) begin
      if (stack[touch_set][i] == touch_way) begin
        touch_pos = way_t'(i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // ways 0..3, most to least recent
      for (int s = 0; s < num_set; s++) begin
        for (int i = 0; i < num_way; i++) begin
          stack[s][i] <= way_t'(i);
        end
      end
    end else if (touch) begin
      // entries above the touched slot slide down one
      for (int i = 1; i < num_way; i++) begin
        if (i <= int'(touch_pos)) begin
          stack[touch_set][i] <= stack[touch_set][i - 1];
        end
      end
      // touched way goes on top
      stack[touch_set][0] <= touch_way;
    end
  end

  // victim for the write path
  assign lru_way = stack[query_set][num_way - 1];

endmodule

/* dcache/cache_way.sv */
// one way of the array; reads are combinational, a write lands on the next clock edge
`timescale 1ns/1ns

module cache_way
  import dcache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  set_t        rd1_set,
  input  set_t        rd2_set,
  input  offset_t     rd1_off,
  input  offset_t     rd2_off,
  input  tag_t        rd1_tag,
  input  tag_t        rd2_tag,
  fill_if.sink        wr,
  input  logic        wr_sel,
  input  logic        wr_replace,
  output logic        rd1_match,
  output logic        rd2_match,
  output logic        wr_match,
  output logic [63:0] rd1_word,
  output logic [63:0] rd2_word
);

  dcache_line_t lines [num_set];

  // write side fields
  set_t                 wr_set;
  offset_t              wr_off;
  logic [num_block-1:0] wr_bit;

  assign wr_set = wr.addr.f.set;
  assign wr_off = wr.addr.f.off;
  // one-hot of the written word
  assign wr_bit = num_block'(1) << wr_off;

  // read hit needs tag and that word's own valid bit
  assign rd1_match = lines[rd1_set].valid[rd1_off] && (lines[rd1_set].tag == rd1_tag);
  assign rd2_match = lines[rd2_set].valid[rd2_off] && (lines[rd2_set].tag == rd2_tag);
  assign rd1_word  = lines[rd1_set].data[rd1_off];
  assign rd2_word  = lines[rd2_set].data[rd2_off];

  // line owns the tag while any word is live
  assign wr_match = (|lines[wr_set].valid) && (lines[wr_set].tag == wr.addr.f.tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_set; s++) begin
        lines[s].valid <= '0;
      end
    end else if (wr.valid && wr_sel) begin
      // new tag here, old words are dropped
      if (wr_replace) begin
        lines[wr_set].valid <= wr_bit;
      end else begin
        lines[wr_set].valid <= lines[wr_set].valid | wr_bit;
      end
      lines[wr_set].tag          <= wr.addr.f.tag;
      lines[wr_set].data[wr_off] <= wr.data;
    end
  end

endmodule

/* common/fill_if.sv */
// one 64-bit word write into the array per cycle; the sink never stalls
`timescale 1ns/1ns

interface fill_if
  import dcache_pkg::*;
();

  logic         valid;
  dcache_addr_u addr;
  logic [63:0]  data;

  // host write side, muxed in at the top
  modport write (output valid, addr, data);

  // miss engine turning responses into fills
  modport fill (output valid, addr, data);

  // array side, takes every valid cycle
  modport sink (input valid, addr, data);

endinterface

/* common/dcache_pkg.sv */
// fixed geometry of 4 ways x 16 sets x 4 words; 32-bit byte address, low 3 bits ignored
package dcache_pkg;

  // cache geometry
  localparam int num_way   = 4;
  localparam int num_set   = 16;
  localparam int num_block = 4;
  localparam int tag_bits  = 23;

  // request slots memory grants after reset
  localparam int mem_credits = 2;

  // index widths
  localparam int way_bits = $clog2(num_way);
  localparam int set_bits = $clog2(num_set);
  localparam int off_bits = $clog2(num_block);

  // miss engine states
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_request = 2'd1;
  localparam logic [1:0] st_wait    = 2'd2;

  typedef logic [way_bits-1:0] way_t;
  typedef logic [set_bits-1:0] set_t;
  typedef logic [off_bits-1:0] offset_t;
  typedef logic [tag_bits-1:0] tag_t;

  // address fields, msb first
  typedef struct packed {
    tag_t       tag;
    set_t       set;
    offset_t    off;
    logic [2:0] byte_off;
  } dcache_fields_t;

  // same 32 bits seen raw or split
  typedef union packed {
    logic [31:0]    raw;
    dcache_fields_t f;
  } dcache_addr_u;

  // one set in one way
  typedef struct packed {
    tag_t                       tag;
    logic [num_block-1:0]       valid;
    logic [num_block-1:0][63:0] data;
  } dcache_line_t;

endpackage
